// File: ip_filter.f
+incdir+include
source/ip_filter_pkg.sv
source/rule_table.sv
source/prefix_matcher.sv
source/accel_io.sv
source/ip_filter_top.sv
test/tb_clock.sv
test/ip_filter_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --timescale 1ns/1ps -j 0
TOP       := ip_filter_tb
FILELIST  := ip_filter.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# grep sets the exit status, so a run without the pass line fails
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx 'NO ERRORS'

clean:
	rm -rf $(OBJ_DIR)

// File: include/ip_filter_tb_tasks.svh
`ifndef IP_FILTER_TB_TASKS_SVH
`define IP_FILTER_TB_TASKS_SVH

  // Shadow copy of the rule table that every rule load keeps in step
  rule_entry_t model_rules [RULE_COUNT];
  logic [31:0] lfsr_state;

  // Galois LFSR that steps once for each bit it hands out
  function automatic logic [31:0] lfsr_bits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      value = {value[30:0], lfsr_state[0]};
      if (lfsr_state[0]) begin
        lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
      end else begin
        lfsr_state = lfsr_state >> 1;
      end
    end
    return value;
  endfunction

  // The bus carries the first octet in bits 7:0
  function automatic io_word_t to_bus_order(input ipv4_addr_t addr);
    io_word_t   word;
    ipv4_addr_t rest;
    word = '0;
    rest = addr;
    for (int i = 0; i < 4; i++) begin
      word = {rest[31:24], word[31:8]};
      rest = rest << 8;
    end
    return word;
  endfunction

  function automatic void clear_model();
    for (int r = 0; r < RULE_COUNT; r++) begin
      model_rules[r[RULE_IDX_WIDTH-1:0]] = '0;
    end
  endfunction

  // First valid rule whose leading plen bits agree with the address wins
  function automatic logic model_lookup(input ipv4_addr_t addr,
                                        output logic [RULE_IDX_WIDTH-1:0] idx);
    rule_entry_t rule;
    int          len;
    idx = '0;
    for (int r = 0; r < RULE_COUNT; r++) begin
      rule = model_rules[r[RULE_IDX_WIDTH-1:0]];
      len  = (rule.plen > 32) ? 32 : int'(rule.plen);
      if (rule.valid && (((addr ^ rule.prefix) >> (32 - len)) == 0)) begin
        idx = r[RULE_IDX_WIDTH-1:0];
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  task automatic check_word(input string name, input io_word_t got, input io_word_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("[FAIL] t=%0d ns %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_result(input io_word_t got, input logic exp_match,
                              input logic [RULE_IDX_WIDTH-1:0] exp_idx);
    io_word_t exp;
    exp    = '0;
    exp[0] = exp_match;
    if (exp_match) begin
      exp[11:8] = exp_idx;
    end
    check_word("io_rd_data (REG_RESULT)", got, exp);
  endtask

  task automatic bus_write(input logic [1:0] offset, input io_word_t data);
    io_en        = 1'b1;
    io_wen       = 1'b1;
    io_strb      = '1;
    io_addr      = '0;
    io_addr[3:2] = offset;
    io_wr_data   = data;
    @(posedge clk);
    #1;
    io_en  = 1'b0;
    io_wen = 1'b0;
  endtask

  task automatic bus_read(input logic [1:0] offset, output io_word_t data, output int waited);
    io_en        = 1'b1;
    io_wen       = 1'b0;
    io_addr      = '0;
    io_addr[3:2] = offset;
    @(posedge clk);
    #1;
    io_en  = 1'b0;
    waited = 1;
    while (!io_rd_valid && waited < READ_LIMIT) begin
      @(posedge clk);
      #1;
      waited++;
    end
    data = io_rd_data;
    if (!io_rd_valid) begin
      check_count++;
      error_count++;
      $display("Read of register offset %0d got no io_rd_valid within %0d cycles",
               offset, READ_LIMIT);
    end else begin
      // Only a result read may wait on the matcher
      if (offset != REG_RESULT) begin
        check_count++;
        if (waited != 1) begin
          error_count++;
          $display("Read of register offset %0d took %0d cycles instead of 1", offset, waited);
        end
      end
      // A read completes with a single valid pulse
      @(posedge clk);
      #1;
      check_count++;
      if (io_rd_valid) begin
        error_count++;
        $display("io_rd_valid for the read of register offset %0d lasted more than one cycle",
                 offset);
      end
    end
  endtask

  task automatic load_rule(input logic [RULE_IDX_WIDTH-1:0] idx, input ipv4_addr_t prefix,
                           input logic [PLEN_WIDTH-1:0] plen, input logic valid);
    rule_entry_t entry;
    entry.prefix     = prefix;
    entry.plen       = plen;
    entry.valid      = valid;
    model_rules[idx] = entry;
    rule_wr_en       = 1'b1;
    rule_wr_idx      = idx;
    rule_wr_data     = entry;
    @(posedge clk);
    #1;
    rule_wr_en = 1'b0;
  endtask

  task automatic write_address(input ipv4_addr_t addr);
    bus_write(REG_SRC_IP, to_bus_order(addr));
    exp_lookups++;
  endtask

  task automatic read_result(input logic exp_match, input logic [RULE_IDX_WIDTH-1:0] exp_idx,
                             output int waited);
    io_word_t data;
    bus_read(REG_RESULT, data, waited);
    check_result(data, exp_match, exp_idx);
    if (exp_match) begin
      exp_hits++;
    end
  endtask

  task automatic lookup_and_check(input ipv4_addr_t addr, input logic exp_match,
                                  input logic [RULE_IDX_WIDTH-1:0] exp_idx);
    int waited;
    write_address(addr);
    read_result(exp_match, exp_idx, waited);
  endtask

  task automatic check_counters(input io_word_t lookups, input io_word_t hits);
    io_word_t data;
    int       waited;
    bus_read(REG_LOOKUPS, data, waited);
    check_word("io_rd_data (REG_LOOKUPS)", data, lookups);
    bus_read(REG_HITS, data, waited);
    check_word("io_rd_data (REG_HITS)", data, hits);
  endtask

`endif

// File: test/ip_filter_tb.sv
`default_nettype none

module ip_filter_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import ip_filter_pkg::*;

  localparam int READ_LIMIT     = 40;
  localparam int TIMEOUT_CYCLES = 4000;

  logic                      clk;
  logic                      rst;
  logic                      io_en;
  logic                      io_wen;
  logic [IO_STRB_WIDTH-1:0]  io_strb;
  logic [IO_ADDR_WIDTH-1:0]  io_addr;
  io_word_t                  io_wr_data;
  io_word_t                  io_rd_data;
  logic                      io_rd_valid;
  logic                      rule_wr_en;
  logic [RULE_IDX_WIDTH-1:0] rule_wr_idx;
  rule_entry_t               rule_wr_data;

  int unsigned cycle_count = 0;
  int unsigned error_count = 0;
  int unsigned check_count = 0;
  int unsigned test_count = 0;
  int unsigned errors_at_start = 0;
  io_word_t    exp_lookups = '0;
  io_word_t    exp_hits = '0;

  `include "ip_filter_tb_tasks.svh"

  tb_clock u_tb_clock (
    .clk (clk)
  );

  ip_filter_top u_ip_filter_top (
    .clk          (clk),
    .rst          (rst),
    .io_en        (io_en),
    .io_wen       (io_wen),
    .io_strb      (io_strb),
    .io_addr      (io_addr),
    .io_wr_data   (io_wr_data),
    .io_rd_data   (io_rd_data),
    .io_rd_valid  (io_rd_valid),
    .rule_wr_en   (rule_wr_en),
    .rule_wr_idx  (rule_wr_idx),
    .rule_wr_data (rule_wr_data)
  );

  // Six tests of at most about 30 bus operations each fit well inside this
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  task automatic finish_test(input string name);
    test_count++;
    if (error_count == errors_at_start) begin
      $display("Test %0d, %s: passed", test_count, name);
    end else begin
      $display("Test %0d, %s: %0d error(s)", test_count, name, error_count - errors_at_start);
    end
    errors_at_start = error_count;
  endtask

  task automatic test_reset_values();
    check_counters('0, '0);
    // Nothing is loaded yet, so any address misses
    lookup_and_check(32'h0a00_0001, 1'b0, 0);
    check_counters(exp_lookups, exp_hits);
  endtask

  task automatic test_src_readback();
    io_word_t data;
    int       waited;
    write_address(32'hc0a8_014d);
    bus_read(REG_SRC_IP, data, waited);
    check_word("io_rd_data (REG_SRC_IP)", data, 32'h4d01_a8c0);
    bus_write(REG_RESULT, 32'hffff_ffff);
    bus_write(REG_HITS, 32'h1234_5678);
    bus_write(REG_LOOKUPS, 32'h8765_4321);
    bus_read(REG_SRC_IP, data, waited);
    check_word("io_rd_data (REG_SRC_IP)", data, 32'h4d01_a8c0);
    read_result(1'b0, 0, waited);
    check_counters(exp_lookups, exp_hits);
  endtask

  task automatic test_prefix_match();
    // Rule 0 would cover every address if it were valid
    load_rule(0, 32'h0000_0000, 0, 1'b0);
    load_rule(2, 32'hc0a8_0100, 24, 1'b1);
    load_rule(3, 32'hc0a8_0000, 16, 1'b1);
    load_rule(5, 32'hac10_0000, 12, 1'b1);
    load_rule(6, 32'h0a01_0203, 32, 1'b1);
    load_rule(7, 32'h0a00_0000, 8, 1'b1);
    load_rule(9, 32'h0102_0304, 40, 1'b1);
    lookup_and_check(32'h0808_0808, 1'b0, 0);
    // Length 0 ignores the stored prefix bits entirely
    load_rule(15, 32'hffff_ffff, 0, 1'b1);
    lookup_and_check(32'hc0a8_014d, 1'b1, 2);   // 192.168.1.77
    lookup_and_check(32'hc0a8_0701, 1'b1, 3);   // 192.168.7.1
    lookup_and_check(32'hac1f_ff01, 1'b1, 5);   // 172.31.255.1
    lookup_and_check(32'hac20_0001, 1'b1, 15);  // 172.32.0.1
    lookup_and_check(32'h0a01_0203, 1'b1, 6);
    lookup_and_check(32'h0a09_0909, 1'b1, 7);
    lookup_and_check(32'h0102_0304, 1'b1, 9);
    lookup_and_check(32'h0102_0305, 1'b1, 15);
  endtask

  task automatic test_stalled_read();
    io_word_t data;
    int       waited;
    lookup_and_check(32'hc0a8_014d, 1'b1, 2);
    // This address runs down to the default rule, so the read has to wait for it
    write_address(32'h0808_0808);
    read_result(1'b1, 15, waited);
    check_count++;
    if (waited <= 1) begin
      error_count++;
      $display("Result read right after the address write did not stall (%0d cycle)", waited);
    end
    bus_read(REG_RESULT, data, waited);
    check_result(data, 1'b1, 15);
    check_count++;
    if (waited != 1) begin
      error_count++;
      $display("Result read of a finished lookup took %0d cycles instead of 1", waited);
    end
  endtask

  task automatic test_restart();
    int waited;
    // The first search is cut short, so only the second one may count as a hit
    write_address(32'hc0a8_014d);
    write_address(32'h0808_0808);
    read_result(1'b1, 15, waited);
    write_address(32'h0808_0808);
    write_address(32'h0a01_0203);
    read_result(1'b1, 6, waited);
    check_counters(exp_lookups, exp_hits);
  endtask

  task automatic test_random_lookups();
    ipv4_addr_t                addr;
    logic                      hit;
    logic [RULE_IDX_WIDTH-1:0] idx;
    int                        waited;
    load_rule(15, '0, 0, 1'b0);
    load_rule(11, 32'h4000_0000, 2, 1'b1);
    for (int i = 0; i < 20; i++) begin
      addr = lfsr_bits(32);
      // Half of the addresses land in 192.168.0.0/16 to exercise rules 2 and 3
      if (lfsr_bits(1) != 0) begin
        addr[31:16] = 16'hc0a8;
      end
      hit = model_lookup(addr, idx);
      write_address(addr);
      read_result(hit, idx, waited);
    end
    check_counters(exp_lookups, exp_hits);
  endtask

  initial begin
    rst          = 1'b1;
    io_en        = 1'b0;
    io_wen       = 1'b0;
    io_strb      = '0;
    io_addr      = '0;
    io_wr_data   = '0;
    rule_wr_en   = 1'b0;
    rule_wr_idx  = '0;
    rule_wr_data = '0;
    lfsr_state   = 32'h73d2_bb17;
    clear_model();
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;

    test_reset_values();
    finish_test("counters and result after reset");
    test_src_readback();
    finish_test("source address readback");
    test_prefix_match();
    finish_test("prefix matching and byte order");
    test_stalled_read();
    finish_test("stalled result read");
    test_restart();
    finish_test("restart by a second write");
    test_random_lookups();
    finish_test("random lookups and counters");

    $display("Summary: %0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: test/tb_clock.sv
`default_nettype none

module tb_clock (
  output logic clk
);
  timeunit 1ns;
  timeprecision 100ps;

  // 4 ns period, starting low
  initial begin
    clk = 1'b0;
  end

  always begin
    #2;
    clk = ~clk;
  end

endmodule

`default_nettype wire

// File: source/ip_filter_top.sv
`default_nettype none

module ip_filter_top (
  input  logic                                      clk,
  input  logic                                      rst,

  input  logic                                      io_en,
  input  logic                                      io_wen,
  input  logic [ip_filter_pkg::IO_STRB_WIDTH-1:0]   io_strb,
  input  logic [ip_filter_pkg::IO_ADDR_WIDTH-1:0]   io_addr,
  input  ip_filter_pkg::io_word_t                   io_wr_data,
  output ip_filter_pkg::io_word_t                   io_rd_data,
  output logic                                      io_rd_valid,

  input  logic                                      rule_wr_en,
  input  logic [ip_filter_pkg::RULE_IDX_WIDTH-1:0]  rule_wr_idx,
  input  ip_filter_pkg::rule_entry_t                rule_wr_data
);
  import ip_filter_pkg::*;

  // Register block to matcher
  logic                      lookup_start;
  ipv4_addr_t                lookup_addr;

  // Matcher results back to the register block
  logic                      match;
  logic [RULE_IDX_WIDTH-1:0] match_idx;
  logic                      done;

  // Matcher to rule table read port
  logic [RULE_IDX_WIDTH-1:0] rd_idx;
  rule_entry_t               rd_rule;

  accel_io u_accel_io (
    .clk          (clk),
    .rst          (rst),
    .io_en        (io_en),
    .io_wen       (io_wen),
    .io_strb      (io_strb),
    .io_addr      (io_addr),
    .io_wr_data   (io_wr_data),
    .io_rd_data   (io_rd_data),
    .io_rd_valid  (io_rd_valid),
    .match        (match),
    .match_idx    (match_idx),
    .done         (done),
    .lookup_start (lookup_start),
    .lookup_addr  (lookup_addr)
  );

  rule_table u_rule_table (
    .clk     (clk),
    .rst     (rst),
    .wr_en   (rule_wr_en),
    .wr_idx  (rule_wr_idx),
    .wr_data (rule_wr_data),
    .rd_idx  (rd_idx),
    .rd_rule (rd_rule)
  );

  prefix_matcher u_prefix_matcher (
    .clk       (clk),
    .rst       (rst),
    .start     (lookup_start),
    .addr      (lookup_addr),
    .rd_rule   (rd_rule),
    .rd_idx    (rd_idx),
    .match     (match),
    .match_idx (match_idx),
    .done      (done)
  );

endmodule

`default_nettype wire

// File: source/accel_io.sv
`default_nettype none

module accel_io (
  input  logic                                      clk,
  input  logic                                      rst,

  input  logic                                      io_en,
  input  logic                                      io_wen,
  input  logic [ip_filter_pkg::IO_STRB_WIDTH-1:0]   io_strb,
  input  logic [ip_filter_pkg::IO_ADDR_WIDTH-1:0]   io_addr,
  input  ip_filter_pkg::io_word_t                   io_wr_data,
  output ip_filter_pkg::io_word_t                   io_rd_data,
  output logic                                      io_rd_valid,

  input  logic                                      match,
  input  logic [ip_filter_pkg::RULE_IDX_WIDTH-1:0]  match_idx,
  input  logic                                      done,
  output logic                                      lookup_start,
  output ip_filter_pkg::ipv4_addr_t                 lookup_addr
);
  import ip_filter_pkg::*;

  io_word_t   src_ip_q;
  io_word_t   lookups_q;
  io_word_t   hits_q;
  io_word_t   result_word;
  logic [1:0] reg_sel;
  logic       wr_req;
  logic       rd_req;
  logic       src_wr;
  logic       result_ready;
  logic       stall_q;
  logic       done_q;

  // The source address is always written as a whole word, so io_strb is ignored
  assign reg_sel = io_addr[3:2];
  assign wr_req  = io_en && io_wen;
  assign rd_req  = io_en && !io_wen;
  assign src_wr  = wr_req && (reg_sel == REG_SRC_IP);

  // A start in flight means the current done belongs to the previous address
  assign result_ready = done && !lookup_start;

  // Bus word arrives in network order, first octet in bits 7:0
  assign lookup_addr = {src_ip_q[7:0], src_ip_q[15:8], src_ip_q[23:16], src_ip_q[31:24]};

  always_comb begin
    result_word       = '0;
    result_word[0]    = match;
    result_word[11:8] = match_idx;
  end

  // Control state, counters and the read handshake
  always_ff @(posedge clk) begin
    if (rst) begin
      lookup_start <= 1'b0;
      io_rd_valid  <= 1'b0;
      stall_q      <= 1'b0;
      done_q       <= 1'b0;
      lookups_q    <= '0;
      hits_q       <= '0;
    end else begin
      lookup_start <= src_wr;
      done_q       <= done;
      io_rd_valid  <= 1'b0;

      if (lookup_start) begin
        lookups_q <= lookups_q + 1'b1;
      end

      // Count a hit once, when done rises with match set
      if (done && !done_q && match) begin
        hits_q <= hits_q + 1'b1;
      end

      if (rd_req) begin
        if (reg_sel != REG_RESULT || result_ready) begin
          io_rd_valid <= 1'b1;
        end else begin
          stall_q <= 1'b1;
        end
      end

      // The requester holds off until this valid, so no other request overlaps
      if (stall_q && done) begin
        io_rd_valid <= 1'b1;
        stall_q     <= 1'b0;
      end
    end
  end

  // Payload registers
  always_ff @(posedge clk) begin
    if (src_wr) begin
      src_ip_q <= io_wr_data;
    end

    if (rd_req) begin
      case (reg_sel)
        REG_SRC_IP:  io_rd_data <= src_ip_q;
        REG_RESULT:  io_rd_data <= result_word;
        REG_HITS:    io_rd_data <= hits_q;
        REG_LOOKUPS: io_rd_data <= lookups_q;
        default:     io_rd_data <= '0;
      endcase
    end else if (stall_q && done) begin
      io_rd_data <= result_word;
    end
  end

endmodule

`default_nettype wire

// File: source/prefix_matcher.sv
`default_nettype none

module prefix_matcher (
  input  logic                                      clk,
  input  logic                                      rst,

  input  logic                                      start,
  input  ip_filter_pkg::ipv4_addr_t                 addr,
  input  ip_filter_pkg::rule_entry_t                rd_rule,

  output logic [ip_filter_pkg::RULE_IDX_WIDTH-1:0]  rd_idx,
  output logic                                      match,
  output logic [ip_filter_pkg::RULE_IDX_WIDTH-1:0]  match_idx,
  output logic                                      done
);
  import ip_filter_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_FILL,
    ST_CMP
  } state_t;

  state_t                    state_q;
  logic [RULE_IDX_WIDTH-1:0] cmp_idx_q;
  logic [PLEN_WIDTH-1:0]     eff_len;
  ipv4_addr_t                mask;
  logic                      hit;

  // Lengths above the address width behave as a full-length prefix
  always_comb begin
    if (rd_rule.plen > PLEN_WIDTH'($bits(ipv4_addr_t))) begin
      eff_len = PLEN_WIDTH'($bits(ipv4_addr_t));
    end else begin
      eff_len = rd_rule.plen;
    end

    if (eff_len == '0) begin
      mask = '0;
    end else begin
      mask = ~ipv4_addr_t'(0) << (PLEN_WIDTH'($bits(ipv4_addr_t)) - eff_len);
    end

    hit = rd_rule.valid && (((addr ^ rd_rule.prefix) & mask) == '0);
  end

  // ST_FILL covers the table's read latency, then one rule is compared per cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q   <= ST_IDLE;
      rd_idx    <= '0;
      cmp_idx_q <= '0;
      match     <= 1'b0;
      match_idx <= '0;
      done      <= 1'b0;
    end else if (start) begin
      // A start in any state restarts the search from rule 0
      state_q   <= ST_FILL;
      rd_idx    <= '0;
      match     <= 1'b0;
      match_idx <= '0;
      done      <= 1'b0;
    end else begin
      case (state_q)
        ST_FILL: begin
          state_q   <= ST_CMP;
          rd_idx    <= rd_idx + 1'b1;
          cmp_idx_q <= '0;
        end
        ST_CMP: begin
          if (hit) begin
            match     <= 1'b1;
            match_idx <= cmp_idx_q;
            done      <= 1'b1;
            state_q   <= ST_IDLE;
          end else if (cmp_idx_q == RULE_IDX_WIDTH'(RULE_COUNT - 1)) begin
            done    <= 1'b1;
            state_q <= ST_IDLE;
          end else begin
            cmp_idx_q <= cmp_idx_q + 1'b1;
            rd_idx    <= rd_idx + 1'b1;
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: source/rule_table.sv
`default_nettype none

module rule_table (
  input  logic                                      clk,
  input  logic                                      rst,

  input  logic                                      wr_en,
  input  logic [ip_filter_pkg::RULE_IDX_WIDTH-1:0]  wr_idx,
  input  ip_filter_pkg::rule_entry_t                wr_data,

  input  logic [ip_filter_pkg::RULE_IDX_WIDTH-1:0]  rd_idx,
  output ip_filter_pkg::rule_entry_t                rd_rule
);
  import ip_filter_pkg::*;

  // Prefix and length live in plain storage, valid bits in a resettable vector
  ipv4_addr_t            prefix_mem [RULE_COUNT];
  logic [PLEN_WIDTH-1:0] plen_mem   [RULE_COUNT];
  logic [RULE_COUNT-1:0] valid_q;

  ipv4_addr_t            rd_prefix_q;
  logic [PLEN_WIDTH-1:0] rd_plen_q;
  logic                  rd_valid_q;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      prefix_mem[wr_idx] <= wr_data.prefix;
      plen_mem[wr_idx]   <= wr_data.plen;
    end

    // Nonblocking reads see the entry as it was before a same-cycle write
    rd_prefix_q <= prefix_mem[rd_idx];
    rd_plen_q   <= plen_mem[rd_idx];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q    <= '0;
      rd_valid_q <= 1'b0;
    end else begin
      if (wr_en) begin
        valid_q[wr_idx] <= wr_data.valid;
      end
      rd_valid_q <= valid_q[rd_idx];
    end
  end

  always_comb begin
    rd_rule        = '0;
    rd_rule.prefix = rd_prefix_q;
    rd_rule.plen   = rd_plen_q;
    rd_rule.valid  = rd_valid_q;
  end

endmodule

`default_nettype wire

// File: source/ip_filter_pkg.sv
`default_nettype none

package ip_filter_pkg;

  // Memory-mapped bus geometry
  localparam int IO_DATA_WIDTH = 32;
  localparam int IO_STRB_WIDTH = IO_DATA_WIDTH / 8;
  localparam int IO_ADDR_WIDTH = 22;

  // Word offsets, decoded from address bits 3:2
  localparam logic [1:0] REG_SRC_IP  = 2'd0;
  localparam logic [1:0] REG_RESULT  = 2'd1;
  localparam logic [1:0] REG_HITS    = 2'd2;
  localparam logic [1:0] REG_LOOKUPS = 2'd3;

  // Rule table geometry
  localparam int RULE_COUNT     = 16;
  localparam int RULE_IDX_WIDTH = 4;
  localparam int PLEN_WIDTH     = 6;

  // Host order, so the first octet sits in bits 31:24
  typedef logic [31:0] ipv4_addr_t;

  typedef logic [IO_DATA_WIDTH-1:0] io_word_t;

  typedef struct packed {
    ipv4_addr_t            prefix;
    logic [PLEN_WIDTH-1:0] plen;
    logic                  valid;
  } rule_entry_t;

endpackage

`default_nettype wire
